//--- design/l2d_pkg.sv
// one bank only; the 7 check bits of each word are plain data here and no ECC is computed
package l2d_pkg;

   ////////////////////////////////////////
   // widths and sizes
   ////////////////////////////////////////

   // one 32-bit word plus its 7 check bits
   localparam int WORD_W     = 39;
   localparam int LINE_WORDS = 16;
   localparam int LINE_W     = LINE_WORDS * WORD_W;
   localparam int COL_WORDS  = 4;
   localparam int COL_W      = COL_WORDS * WORD_W;
   // store data is two words
   localparam int ST_W       = 2 * WORD_W;

   localparam int NUM_SETS   = 64;
   localparam int SET_W      = 6;
   localparam int NUM_WAYS   = 4;
   localparam int FB_ENTRIES = 4;
   localparam int FB_IDX_W   = 2;
   localparam int NUM_COLS   = LINE_WORDS / COL_WORDS;

   ////////////////////////////////////////
   // vector types
   ////////////////////////////////////////

   typedef logic [LINE_W-1:0]     line_t;
   typedef logic [COL_W-1:0]      col_t;
   typedef logic [ST_W-1:0]       st_data_t;
   typedef logic [SET_W-1:0]      set_t;
   typedef logic [NUM_WAYS-1:0]   way_sel_t;
   typedef logic [LINE_WORDS-1:0] word_en_t;
   typedef logic [NUM_COLS-1:0]   col_sel_t;
   typedef logic [FB_IDX_W-1:0]   fb_idx_t;

   // even words get the low store word, odd words the high one
   function automatic line_t st_expand(input st_data_t st);
      line_t line;
      line = '0;
      for (int k = 0; k < LINE_WORDS / 2; k++) begin
         line[(2*k)*WORD_W +: WORD_W]   = st[WORD_W-1:0];
         line[(2*k+1)*WORD_W +: WORD_W] = st[ST_W-1:WORD_W];
      end
      return line;
   endfunction

endpackage

//--- design/l2d_ctr_io.sv
// fixed 4-cycle read latency with no hold; col_sel_c2 must be one-hot and a fill write must follow its fill read by two cycles
module l2d_ctr_io
   import l2d_pkg::*;
(
   input  logic     rclk,
   input  logic     rst_n,

   // request from the tag side at c2
   input  way_sel_t way_sel_c2,
   input  logic     rd_wr_c2,
   input  set_t     set_c2,
   input  col_sel_t col_sel_c2,
   input  word_en_t word_en_c2,
   input  st_data_t st_data_c2,

   // fill controls arrive one cycle later, at c3
   input  logic     fbrd_c3,
   input  logic     fb_hit_c3,

   input  line_t    fb_data_c5,
   input  line_t    array_data_c5,

   // array write port and read address
   output way_sel_t array_way_sel_c3,
   output set_t     array_set_c3,
   output logic     array_wr_en_c3,
   output word_en_t array_word_en_c3,
   output line_t    array_data_in_c3,

   output line_t    rd_line_c6,
   output col_t     rd_col_c6
);

   st_data_t st_data_c3;

   col_sel_t col_sel_c3;
   col_sel_t col_sel_c4;
   col_sel_t col_sel_c5;

   logic     fbrd_c4;
   logic     fbrd_c5;
   logic     fb_hit_c4;
   logic     fb_hit_c5;

   line_t    rd_line_c5;
   col_t     col_01_c5;
   col_t     col_23_c5;
   logic     sel_23_c5;
   col_t     col_c5;

   ////////////////////////////////////////
   // c2 -> c3 request registers
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      array_way_sel_c3 <= way_sel_c2;
      array_set_c3     <= set_c2;
      array_word_en_c3 <= word_en_c2;
      st_data_c3       <= st_data_c2;
      col_sel_c3       <= col_sel_c2;
   end

   // a read is rd_wr = 1, so the write enable is its inverse
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         array_wr_en_c3 <= 1'b0;
      end else begin
         array_wr_en_c3 <= ~rd_wr_c2;
      end
   end

   ////////////////////////////////////////
   // c3 -> c5 delay of the read controls
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      col_sel_c4 <= col_sel_c3;
      col_sel_c5 <= col_sel_c4;
   end

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         fbrd_c4   <= 1'b0;
         fbrd_c5   <= 1'b0;
         fb_hit_c4 <= 1'b0;
         fb_hit_c5 <= 1'b0;
      end else begin
         fbrd_c4   <= fbrd_c3;
         fbrd_c5   <= fbrd_c4;
         fb_hit_c4 <= fb_hit_c3;
         fb_hit_c5 <= fb_hit_c4;
      end
   end

   // the fill read that set fbrd_c5 is two ops ahead of this write,
   // so its fill line is on fb_data_c5 now
   assign array_data_in_c3 = fbrd_c5 ? fb_data_c5 : st_expand(st_data_c3);

   ////////////////////////////////////////
   // c5 read select and column mux
   ////////////////////////////////////////

   // bypass the array on a fill-buffer hit
   assign rd_line_c5 = fb_hit_c5 ? fb_data_c5 : array_data_c5;

   // first level picks within each half of the line
   assign col_01_c5 = col_sel_c5[0] ? rd_line_c5[0*COL_W +: COL_W]
                                    : rd_line_c5[1*COL_W +: COL_W];
   assign col_23_c5 = col_sel_c5[2] ? rd_line_c5[2*COL_W +: COL_W]
                                    : rd_line_c5[3*COL_W +: COL_W];

   // second level picks the half
   assign sel_23_c5 = col_sel_c5[3] | col_sel_c5[2];
   assign col_c5    = sel_23_c5 ? col_23_c5 : col_01_c5;

   always_ff @(posedge rclk) begin
      rd_line_c6 <= rd_line_c5;
      rd_col_c6  <= col_c5;
   end

endmodule

//--- design/l2d_array.sv
// behavioral array, contents start at zero; a read way_sel that is not one-hot returns the OR of the selected ways
module l2d_array
   import l2d_pkg::*;
(
   input  logic     rclk,

   // c3 access, shared by reads and writes
   input  way_sel_t way_sel_c3,
   input  set_t     set_c3,
   input  logic     wr_en_c3,
   input  word_en_t word_en_c3,
   input  line_t    data_in_c3,

   output line_t    data_c5
);

   ////////////////////////////////////////
   // storage
   ////////////////////////////////////////

   line_t mem [NUM_SETS][NUM_WAYS] = '{default: '0};

   line_t rd_line_c3;
   line_t data_c4;

   // per-word write, only the enabled words of the selected ways change
   always_ff @(posedge rclk) begin
      if (wr_en_c3) begin
         for (int w = 0; w < NUM_WAYS; w++) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
               if (way_sel_c3[w] && word_en_c3[i]) begin
                  mem[set_c3][w][i*WORD_W +: WORD_W] <= data_in_c3[i*WORD_W +: WORD_W];
               end
            end
         end
      end
   end

   ////////////////////////////////////////
   // read path
   ////////////////////////////////////////

   // way read-out is a wired OR of the selected ways
   always_comb begin
      rd_line_c3 = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (way_sel_c3[w]) begin
            rd_line_c3 = rd_line_c3 | mem[set_c3][w];
         end
      end
   end

   // c4 holds through a write cycle
   always_ff @(posedge rclk) begin
      if (!wr_en_c3) begin
         data_c4 <= rd_line_c3;
      end
   end

   always_ff @(posedge rclk) begin
      data_c5 <= data_c4;
   end

endmodule

//--- design/l2d_fill_buf.sv
// entries start at zero and are loaded only through the fill port; a load and a c3 read of one entry in the same cycle return the old line
module l2d_fill_buf
   import l2d_pkg::*;
(
   input  logic    rclk,

   // load port
   input  logic    fill_wr,
   input  fb_idx_t fill_idx,
   input  line_t   fill_data,

   // read index from the tag side at c3
   input  fb_idx_t rd_idx_c3,
   output line_t   data_c5
);

   ////////////////////////////////////////
   // entries
   ////////////////////////////////////////

   line_t entry [FB_ENTRIES] = '{default: '0};

   line_t data_c4;

   always_ff @(posedge rclk) begin
      if (fill_wr) begin
         entry[fill_idx] <= fill_data;
      end
   end

   ////////////////////////////////////////
   // read, two stages to meet c5
   ////////////////////////////////////////

   // same depth as the array read so bypass and fill data line up
   always_ff @(posedge rclk) begin
      data_c4 <= entry[rd_idx_c3];
      data_c5 <= data_c4;
   end

endmodule

//--- design/l2d_bank_top.sv
// one bank with fixed 4-cycle read latency and no back-pressure; fill controls for a request come one cycle after it
module l2d_bank_top
   import l2d_pkg::*;
(
   input  logic     rclk,
   input  logic     rst_n,

   // request at c2
   input  way_sel_t req_way_sel,
   input  logic     req_rd_wr,
   input  set_t     req_set,
   input  col_sel_t req_col_sel,
   input  word_en_t req_word_en,
   input  st_data_t req_st_data,

   // fill controls for the same request at c3
   input  logic     req_fbrd,
   input  logic     req_fb_hit,
   input  fb_idx_t  req_fb_idx,

   // fill buffer load port
   input  logic     fill_wr,
   input  fb_idx_t  fill_idx,
   input  line_t    fill_data,

   output line_t    rd_line_c6,
   output col_t     rd_col_c6
);

   way_sel_t array_way_sel_c3;
   set_t     array_set_c3;
   logic     array_wr_en_c3;
   word_en_t array_word_en_c3;
   line_t    array_data_in_c3;
   line_t    array_data_c5;
   line_t    fb_data_c5;

   l2d_ctr_io u_ctr_io (
      .rclk             (rclk),
      .rst_n            (rst_n),
      .way_sel_c2       (req_way_sel),
      .rd_wr_c2         (req_rd_wr),
      .set_c2           (req_set),
      .col_sel_c2       (req_col_sel),
      .word_en_c2       (req_word_en),
      .st_data_c2       (req_st_data),
      .fbrd_c3          (req_fbrd),
      .fb_hit_c3        (req_fb_hit),
      .fb_data_c5       (fb_data_c5),
      .array_data_c5    (array_data_c5),
      .array_way_sel_c3 (array_way_sel_c3),
      .array_set_c3     (array_set_c3),
      .array_wr_en_c3   (array_wr_en_c3),
      .array_word_en_c3 (array_word_en_c3),
      .array_data_in_c3 (array_data_in_c3),
      .rd_line_c6       (rd_line_c6),
      .rd_col_c6        (rd_col_c6)
   );

   l2d_array u_array (
      .rclk       (rclk),
      .way_sel_c3 (array_way_sel_c3),
      .set_c3     (array_set_c3),
      .wr_en_c3   (array_wr_en_c3),
      .word_en_c3 (array_word_en_c3),
      .data_in_c3 (array_data_in_c3),
      .data_c5    (array_data_c5)
   );

   l2d_fill_buf u_fill_buf (
      .rclk      (rclk),
      .fill_wr   (fill_wr),
      .fill_idx  (fill_idx),
      .fill_data (fill_data),
      .rd_idx_c3 (req_fb_idx),
      .data_c5   (fb_data_c5)
   );

endmodule

//--- dv/l2d_tb_asserts.sv
// request rules at the control block; all checks but the reset one are off while rst_n is low
module l2d_ctr_io_asserts
   import l2d_pkg::*;
(
   input logic     rclk,
   input logic     rst_n,
   input way_sel_t way_sel_c2,
   input logic     rd_wr_c2,
   input col_sel_t col_sel_c2,
   input logic     fbrd_c3,
   input logic     fb_hit_c3,
   input logic     array_wr_en_c3
);

   // failures seen so far, read by the testbench at the end
   int fail_count = 0;

   // no write may come out of reset
   wr_en_after_reset: assert property (@(posedge rclk) !rst_n |=> !array_wr_en_c3)
      else begin
         $error("array write enable set in the cycle after reset");
         fail_count++;
      end

   col_sel_onehot: assert property (@(posedge rclk) disable iff (!rst_n)
      $onehot(col_sel_c2))
      else begin
         $error("col_sel_c2 is not one-hot: %b", col_sel_c2);
         fail_count++;
      end

   wr_way_onehot: assert property (@(posedge rclk) disable iff (!rst_n)
      !rd_wr_c2 |-> $onehot(way_sel_c2))
      else begin
         $error("write with way_sel_c2 not one-hot: %b", way_sel_c2);
         fail_count++;
      end

   // a request is either a fill read or a bypass read, never both
   fill_flags_exclusive: assert property (@(posedge rclk) disable iff (!rst_n)
      !(fbrd_c3 && fb_hit_c3))
      else begin
         $error("fbrd_c3 and fb_hit_c3 set together");
         fail_count++;
      end

endmodule

bind l2d_ctr_io l2d_ctr_io_asserts u_asserts (
   .rclk           (rclk),
   .rst_n          (rst_n),
   .way_sel_c2     (way_sel_c2),
   .rd_wr_c2       (rd_wr_c2),
   .col_sel_c2     (col_sel_c2),
   .fbrd_c3        (fbrd_c3),
   .fb_hit_c3      (fb_hit_c3),
   .array_wr_en_c3 (array_wr_en_c3)
);

//--- dv/l2d_tb.sv
// bank testbench; fill loads never share a cycle with the c3 read of a bypass or fill read
module l2d_tb
   import l2d_pkg::*;
();

   localparam int          LATENCY     = 4;
   // all tests together run a few hundred cycles, the limit leaves wide margin
   localparam int          TIMEOUT_CYC = 3000;
   localparam int          TRAFFIC_OPS = 300;
   localparam logic [15:0] LFSR_SEED   = 16'd64719;
   localparam logic [15:0] LFSR_TAPS   = 16'hB400;

   logic     rclk = 1'b0;
   logic     rst_n;
   way_sel_t req_way_sel;
   logic     req_rd_wr;
   set_t     req_set;
   col_sel_t req_col_sel;
   word_en_t req_word_en;
   st_data_t req_st_data;
   logic     req_fbrd;
   logic     req_fb_hit;
   fb_idx_t  req_fb_idx;
   logic     fill_wr;
   fb_idx_t  fill_idx;
   line_t    fill_data;
   line_t    rd_line_c6;
   col_t     rd_col_c6;

   // reference copies of the array and the fill buffer
   line_t mem_model [NUM_SETS][NUM_WAYS] = '{default: '0};
   line_t fb_model [FB_ENTRIES] = '{default: '0};

   // reads waiting for their c6 cycle
   int    due_q[$];
   line_t line_q[$];
   col_t  col_q[$];

   // fill controls of the last two requests
   logic    fbrd_d1 = 1'b0;
   logic    hit_d1  = 1'b0;
   fb_idx_t idx_d1  = '0;
   logic    fbrd_d2 = 1'b0;
   fb_idx_t idx_d2  = '0;

   logic [15:0] lfsr_state = LFSR_SEED;
   int          cyc        = 0;
   int          checks     = 0;
   int          errors     = 0;
   int          test_num   = 1;
   int          chk_base   = 0;
   int          err_base   = 0;
   int          total_errors;

   l2d_bank_top u_dut (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .req_way_sel (req_way_sel),
      .req_rd_wr   (req_rd_wr),
      .req_set     (req_set),
      .req_col_sel (req_col_sel),
      .req_word_en (req_word_en),
      .req_st_data (req_st_data),
      .req_fbrd    (req_fbrd),
      .req_fb_hit  (req_fb_hit),
      .req_fb_idx  (req_fb_idx),
      .fill_wr     (fill_wr),
      .fill_idx    (fill_idx),
      .fill_data   (fill_data),
      .rd_line_c6  (rd_line_c6),
      .rd_col_c6   (rd_col_c6)
   );

   always #10 rclk = ~rclk;

   ////////////////////////////////////////
   // random data and reference model
   ////////////////////////////////////////

   // one LFSR step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i]       = lfsr_state[0];
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      end
      return v;
   endfunction

   function automatic st_data_t rand_store();
      logic [63:0] lo;
      logic [63:0] hi;
      lo = rand_bits(WORD_W);
      hi = rand_bits(WORD_W);
      return {hi[WORD_W-1:0], lo[WORD_W-1:0]};
   endfunction

   function automatic line_t rand_line();
      line_t       l;
      logic [63:0] r;
      for (int i = 0; i < LINE_WORDS; i++) begin
         r = rand_bits(WORD_W);
         l[i*WORD_W +: WORD_W] = r[WORD_W-1:0];
      end
      return l;
   endfunction

   // even words take the low store word, odd words the high one
   function automatic line_t spread_store(input st_data_t st);
      line_t l;
      for (int i = 0; i < LINE_WORDS; i++) begin
         if (i % 2 == 0) begin
            l[i*WORD_W +: WORD_W] = st[WORD_W-1:0];
         end else begin
            l[i*WORD_W +: WORD_W] = st[ST_W-1:WORD_W];
         end
      end
      return l;
   endfunction

   function automatic line_t merge_words(input line_t old_line, input line_t new_line,
                                         input word_en_t en);
      line_t l;
      l = old_line;
      for (int i = 0; i < LINE_WORDS; i++) begin
         if (en[i]) begin
            l[i*WORD_W +: WORD_W] = new_line[i*WORD_W +: WORD_W];
         end
      end
      return l;
   endfunction

   function automatic line_t exp_read(input set_t set_idx, input int way, input logic byp,
                                      input fb_idx_t idx);
      if (byp) begin
         return fb_model[idx];
      end
      return mem_model[set_idx][way];
   endfunction

   ////////////////////////////////////////
   // compare
   ////////////////////////////////////////

   task automatic check_line(input string name, input line_t expected, input line_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail t=%0t %s exp=%h act=%h", $time, name, expected, actual);
      end
   endtask

   task automatic check_col(input string name, input col_t expected, input col_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail t=%0t %s exp=%h act=%h", $time, name, expected, actual);
      end
   endtask

   // outputs settle after the rising edge, so sample on the falling one
   always @(negedge rclk) begin
      int    due;
      line_t exp_line;
      col_t  exp_col;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
         due      = due_q.pop_front();
         exp_line = line_q.pop_front();
         exp_col  = col_q.pop_front();
         if (due < cyc) begin
            errors++;
            $display("read due at cycle %0d was never compared", due);
         end else begin
            check_line("rd_line_c6", exp_line, rd_line_c6);
            check_col("rd_col_c6", exp_col, rd_col_c6);
         end
      end
   end

   always @(posedge rclk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYC) begin
         $display("timeout after %0d cycles, %0d reads still pending", cyc, due_q.size());
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // request driver
   ////////////////////////////////////////

   // one request per cycle; the previous request's fill controls go out with it
   task automatic issue(input logic rd_wr, input set_t set_idx, input int way, input int col,
                        input word_en_t en, input st_data_t st, input logic fbrd,
                        input logic byp, input fb_idx_t idx, input logic chk);
      line_t exp_line;
      line_t src;
      @(posedge rclk);
      #2;
      fill_wr     = 1'b0;
      req_fbrd    = fbrd_d1;
      req_fb_hit  = hit_d1;
      req_fb_idx  = idx_d1;
      req_rd_wr   = rd_wr;
      req_set     = set_idx;
      req_way_sel = way_sel_t'(1 << way);
      req_col_sel = col_sel_t'(1 << col);
      req_word_en = en;
      req_st_data = st;
      if (rd_wr && chk) begin
         exp_line = exp_read(set_idx, way, byp, idx);
         due_q.push_back(cyc + LATENCY);
         line_q.push_back(exp_line);
         col_q.push_back(exp_line[col*COL_W +: COL_W]);
      end
      // a write sampled in reset is lost; a fill read two ops back supplies the data
      if (!rd_wr && rst_n) begin
         src = fbrd_d2 ? fb_model[idx_d2] : spread_store(st);
         mem_model[set_idx][way] = merge_words(mem_model[set_idx][way], src, en);
      end
      fbrd_d2 = fbrd_d1;
      idx_d2  = idx_d1;
      fbrd_d1 = fbrd;
      hit_d1  = byp;
      idx_d1  = idx;
   endtask

   task automatic idle();
      issue(1'b1, '0, 0, 0, '0, '0, 1'b0, 1'b0, '0, 1'b0);
   endtask

   task automatic rd(input set_t s, input int w, input int c, input logic byp, input fb_idx_t i);
      issue(1'b1, s, w, c, '0, '0, 1'b0, byp, i, 1'b1);
   endtask

   task automatic wr(input set_t s, input int w, input word_en_t en, input st_data_t st);
      issue(1'b0, s, w, 0, en, st, 1'b0, 1'b0, '0, 1'b0);
   endtask

   task automatic load_fill(input fb_idx_t idx, input line_t line);
      idle();
      fill_wr       = 1'b1;
      fill_idx      = idx;
      fill_data     = line;
      fb_model[idx] = line;
   endtask

   task automatic drain();
      while (due_q.size() > 0) begin
         idle();
      end
   endtask

   task automatic finish_test(input string name);
      drain();
      $display("test %0d %s: %0d checks, %0d errors", test_num, name,
               checks - chk_base, errors - err_base);
      test_num++;
      chk_base = checks;
      err_base = errors;
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   task automatic store_test();
      set_t     sets [16];
      int       ways [16];
      word_en_t en;
      for (int round = 0; round < 2; round++) begin
         for (int i = 0; i < 16; i++) begin
            if (round == 0) begin
               sets[i] = set_t'(rand_bits(SET_W));
               ways[i] = int'(rand_bits(2));
            end
            en = word_en_t'(rand_bits(LINE_WORDS));
            wr(sets[i], ways[i], en, rand_store());
         end
         for (int i = 0; i < 16; i++) begin
            rd(sets[i], ways[i], int'(rand_bits(2)), 1'b0, '0);
         end
      end
      finish_test("store with word enables");
   endtask

   task automatic column_test();
      set_t sets [2];
      int   ways [2];
      sets[0] = set_t'(10);
      ways[0] = 1;
      sets[1] = set_t'(33);
      ways[1] = 3;
      // one word pair per write, so every word of the line differs
      for (int l = 0; l < 2; l++) begin
         for (int k = 0; k < LINE_WORDS / 2; k++) begin
            wr(sets[l], ways[l], word_en_t'(3 << (2 * k)), rand_store());
         end
      end
      for (int c = 0; c < NUM_COLS; c++) begin
         rd(sets[0], ways[0], c, 1'b0, '0);
         rd(sets[1], ways[1], c, 1'b0, '0);
      end
      finish_test("column select");
   endtask

   task automatic bypass_test();
      set_t s;
      int   w;
      for (int e = 0; e < FB_ENTRIES; e++) begin
         load_fill(fb_idx_t'(e), rand_line());
      end
      for (int e = 0; e < FB_ENTRIES; e++) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            s = set_t'(rand_bits(SET_W));
            w = int'(rand_bits(2));
            rd(s, w, c, 1'b0, '0);
            rd(s, w, c, 1'b1, fb_idx_t'(e));
         end
      end
      finish_test("fill bypass");
   endtask

   task automatic fill_write_test();
      set_t     s;
      int       w;
      word_en_t en;
      for (int i = 0; i < FB_ENTRIES; i++) begin
         s  = set_t'(rand_bits(SET_W));
         w  = int'(rand_bits(2));
         en = word_en_t'(rand_bits(LINE_WORDS));
         // fill read, one op gap, then the write that takes the fill line
         issue(1'b1, set_t'(rand_bits(SET_W)), 0, 0, '0, '0, 1'b1, 1'b0, fb_idx_t'(i), 1'b1);
         idle();
         wr(s, w, en, rand_store());
         for (int c = 0; c < NUM_COLS; c++) begin
            rd(s, w, c, 1'b0, '0);
         end
      end
      finish_test("fill write");
   endtask

   task automatic traffic_test();
      logic [63:0] r;
      set_t        s;
      int          w;
      int          c;
      int          ops;
      ops = 0;
      while (ops < TRAFFIC_OPS) begin
         r = rand_bits(2);
         // few sets, so reads often hit recently written lines
         s = set_t'(rand_bits(3));
         w = int'(rand_bits(2));
         c = int'(rand_bits(2));
         if (r[1:0] == 2'd0) begin
            wr(s, w, word_en_t'(rand_bits(LINE_WORDS)), rand_store());
            rd(s, w, c, 1'b0, '0);
            ops += 2;
         end else if (r[1:0] == 2'd3) begin
            rd(s, w, c, 1'b1, fb_idx_t'(rand_bits(FB_IDX_W)));
            ops++;
         end else begin
            rd(s, w, c, 1'b0, '0);
            ops++;
         end
      end
      finish_test("back-to-back traffic");
   endtask

   task automatic reset_test();
      set_t     s;
      st_data_t st;
      s  = set_t'(rand_bits(SET_W));
      st = rand_store();
      wr(s, 2, '1, st);
      idle();
      rst_n = 1'b0;
      idle();
      idle();
      // sampled with rst_n still low
      wr(s, 2, '1, ~st);
      idle();
      rst_n = 1'b1;
      for (int c = 0; c < NUM_COLS; c++) begin
         rd(s, 2, c, 1'b0, '0);
      end
      finish_test("reset drops a pending write");
   endtask

   initial begin
      rst_n       = 1'b0;
      req_way_sel = way_sel_t'(1);
      req_rd_wr   = 1'b1;
      req_set     = '0;
      req_col_sel = col_sel_t'(1);
      req_word_en = '0;
      req_st_data = '0;
      req_fbrd    = 1'b0;
      req_fb_hit  = 1'b0;
      req_fb_idx  = '0;
      fill_wr     = 1'b0;
      fill_idx    = '0;
      fill_data   = '0;
      repeat (5) idle();
      rst_n = 1'b1;
      store_test();
      column_test();
      bypass_test();
      fill_write_test();
      traffic_test();
      reset_test();
      total_errors = errors + u_dut.u_ctr_io.u_asserts.fail_count;
      $display("done: %0d checks, %0d compare errors, %0d assertion failures",
               checks, errors, u_dut.u_ctr_io.u_asserts.fail_count);
      if (total_errors == 0 && checks > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
design/l2d_pkg.sv
design/l2d_ctr_io.sv
design/l2d_array.sv
design/l2d_fill_buf.sv
design/l2d_bank_top.sv
dv/l2d_tb_asserts.sv
dv/l2d_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module l2d_tb -Mdir obj_dir -o l2d_sim \
   -f project.f || exit 1
out=$(./obj_dir/l2d_sim)
echo "$out"
echo "$out" | grep -q "^TESTBENCH PASSED$" && exit 0 || exit 1
